// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_frontend -o tb_frontend
./obj_dir/tb_frontend | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation ok"
else
    echo "simulation reported errors"
    exit 1
fi

// File: sim.f
+incdir+source
source/bpu_pkg.sv
source/bht.sv
source/btb.sv
source/bpu.sv
source/pc_gen.sv
source/inst_buffer.sv
source/frontend_top.sv
testbench/tb_frontend.sv

// File: source/bht.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_cfg.svh"

module bht
    import bpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t rd_pc_1,
    input  wire addr_t rd_pc_2,
    input  wire logic  update_en,
    input  wire addr_t update_pc,
    input  wire logic  update_taken,
    output logic       taken_1,
    output logic       taken_2
);

    localparam int unsigned ENTRIES = 2 ** `BHT_IDX_W;

    bht_cnt_t counters [ENTRIES];
    logic [`BHT_IDX_W-1:0] upd_idx;
    bht_cnt_t upd_cnt;

    // Upper bit of the counter is the prediction
    assign taken_1 = counters[rd_pc_1[`BHT_IDX_W+1:2]][1];
    assign taken_2 = counters[rd_pc_2[`BHT_IDX_W+1:2]][1];

    assign upd_idx = update_pc[`BHT_IDX_W+1:2];
    assign upd_cnt = counters[upd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'd1;
            end
        end else if (update_en) begin
            // Saturate at both ends
            if (update_taken && upd_cnt != 2'd3) begin
                counters[upd_idx] <= upd_cnt + 2'd1;
            end else if (!update_taken && upd_cnt != 2'd0) begin
                counters[upd_idx] <= upd_cnt - 2'd1;
            end
        end
    end

    a_update_aligned: assert property (@(posedge clk) disable iff (rst)
        update_en |-> update_pc[1:0] == 2'b00)
        else $error("bht: update_pc %h not word aligned", update_pc);

endmodule

`default_nettype wire

// File: source/bpu.sv
`timescale 1ns/1ps
`default_nettype none

module bpu
    import bpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t fetch_pc,
    input  wire inst_t inst_1,
    input  wire inst_t inst_2,
    input  wire logic  stall,
    input  wire logic  branch_flush,
    input  wire logic  update_en,
    input  wire logic  update_taken,
    input  wire addr_t update_pc,
    input  wire addr_t update_target,
    output logic       redirect,
    output addr_t      redirect_pc,
    output logic       push_1,
    output logic       push_2,
    output logic       push_pred_1,
    output logic       push_pred_2
);

    opcode_t op_1;
    opcode_t op_2;
    addr_t   pc_2;
    logic    is_br_1, is_br_2;
    logic    taken_1, taken_2;
    logic    hit_1, hit_2;
    addr_t   target_1, target_2;
    logic    pred_1, pred_2;
    logic    push_en;

    // Branch opcodes 0x12 to 0x1B
    function automatic logic is_branch(input opcode_t op);
        return op >= 6'h12 && op <= 6'h1b;
    endfunction

    assign op_1 = inst_1[31:26];
    assign op_2 = inst_2[31:26];
    assign pc_2 = fetch_pc + 32'd4;

    assign is_br_1 = is_branch(op_1);
    assign is_br_2 = is_branch(op_2);

    bht u_bht (
        .clk(clk), .rst(rst),
        .rd_pc_1(fetch_pc), .rd_pc_2(pc_2),
        .update_en(update_en), .update_pc(update_pc), .update_taken(update_taken),
        .taken_1(taken_1), .taken_2(taken_2)
    );

    btb u_btb (
        .clk(clk), .rst(rst),
        .rd_pc_1(fetch_pc), .rd_pc_2(pc_2),
        .update_en(update_en), .update_taken(update_taken),
        .update_pc(update_pc), .update_target(update_target),
        .hit_1(hit_1), .hit_2(hit_2), .target_1(target_1), .target_2(target_2)
    );

    ////////////////////////////////////////////////////////////
    // Slot selection
    assign pred_1 = is_br_1 && taken_1 && hit_1;
    assign pred_2 = is_br_2 && taken_2 && hit_2;

    // Slot 1 wins and a taken slot 1 drops slot 2
    assign redirect    = pred_1 || pred_2;
    assign redirect_pc = pred_1 ? target_1 : target_2;

    assign push_en     = !stall && !branch_flush;
    assign push_1      = push_en;
    assign push_2      = push_en && !pred_1;
    assign push_pred_1 = push_en && pred_1;
    assign push_pred_2 = push_en && !pred_1 && pred_2;

endmodule

`default_nettype wire

// File: source/bpu_cfg.svh
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// History table index width, 64 counters on pc[7:2]
`define BHT_IDX_W 6

// Target buffer index width, 32 entries on pc[6:2]
`define BTB_IDX_W 5

// Instruction buffer entries, power of two and at least 4
`define BUF_DEPTH 8

// First fetch address out of reset
`define RESET_PC 32'h1c00_0000

`endif

// File: source/bpu_pkg.sv
`default_nettype none

`include "bpu_cfg.svh"

package bpu_pkg;

    // One instruction address, word granular
    typedef logic [31:0] addr_t;

    // Raw instruction word from fetch
    typedef logic [31:0] inst_t;

    // Major opcode, bits 31..26 of a word
    typedef logic [5:0] opcode_t;

    // Saturating history counter, 2 and 3 predict taken
    typedef logic [1:0] bht_cnt_t;

    // Address bits above the BTB index and the byte offset
    typedef logic [32-2-`BTB_IDX_W-1:0] btb_tag_t;

endpackage

`default_nettype wire

// File: source/btb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_cfg.svh"

module btb
    import bpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t rd_pc_1,
    input  wire addr_t rd_pc_2,
    input  wire logic  update_en,
    input  wire logic  update_taken,
    input  wire addr_t update_pc,
    input  wire addr_t update_target,
    output logic       hit_1,
    output logic       hit_2,
    output addr_t      target_1,
    output addr_t      target_2
);

    localparam int unsigned ENTRIES = 2 ** `BTB_IDX_W;

    btb_tag_t tags    [ENTRIES];
    addr_t    targets [ENTRIES];
    logic     valid   [ENTRIES];

    logic [`BTB_IDX_W-1:0] idx_1;
    logic [`BTB_IDX_W-1:0] idx_2;
    logic [`BTB_IDX_W-1:0] upd_idx;
    logic                  upd_write;

    assign idx_1   = rd_pc_1[`BTB_IDX_W+1:2];
    assign idx_2   = rd_pc_2[`BTB_IDX_W+1:2];
    assign upd_idx = update_pc[`BTB_IDX_W+1:2];

    // Not-taken outcomes leave the entry alone
    assign upd_write = update_en && update_taken;

    ////////////////////////////////////////////////////////////
    // Lookup
    assign hit_1    = valid[idx_1] && tags[idx_1] == rd_pc_1[31:`BTB_IDX_W+2];
    assign hit_2    = valid[idx_2] && tags[idx_2] == rd_pc_2[31:`BTB_IDX_W+2];
    assign target_1 = targets[idx_1];
    assign target_2 = targets[idx_2];

    ////////////////////////////////////////////////////////////
    // Update
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (upd_write) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_write) begin
            tags[upd_idx]    <= update_pc[31:`BTB_IDX_W+2];
            targets[upd_idx] <= update_target;
        end
    end

endmodule

`default_nettype wire

// File: source/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import bpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    output addr_t      fetch_pc,
    input  wire inst_t inst_1,
    input  wire inst_t inst_2,
    input  wire logic  update_en,
    input  wire addr_t update_pc,
    input  wire logic  update_taken,
    input  wire addr_t update_target,
    input  wire logic  branch_flush,
    input  wire addr_t flush_pc,
    input  wire logic  out_ready,
    output logic       out_valid,
    output addr_t      out_pc,
    output inst_t      out_inst,
    output logic       out_pred
);

    logic  redirect, stall;
    addr_t redirect_pc;
    logic  push_1, push_2, push_pred_1, push_pred_2;

    pc_gen u_pc_gen (
        .clk(clk), .rst(rst), .stall(stall), .branch_flush(branch_flush),
        .redirect(redirect), .flush_pc(flush_pc), .redirect_pc(redirect_pc),
        .fetch_pc(fetch_pc)
    );

    bpu u_bpu (
        .clk(clk), .rst(rst), .fetch_pc(fetch_pc), .inst_1(inst_1), .inst_2(inst_2),
        .stall(stall), .branch_flush(branch_flush),
        .update_en(update_en), .update_taken(update_taken),
        .update_pc(update_pc), .update_target(update_target),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .push_1(push_1), .push_2(push_2),
        .push_pred_1(push_pred_1), .push_pred_2(push_pred_2)
    );

    inst_buffer u_inst_buffer (
        .clk(clk), .rst(rst), .branch_flush(branch_flush),
        .push_1(push_1), .push_2(push_2),
        .push_pred_1(push_pred_1), .push_pred_2(push_pred_2),
        .fetch_pc(fetch_pc), .inst_1(inst_1), .inst_2(inst_2),
        .out_ready(out_ready), .stall(stall), .out_valid(out_valid),
        .out_pc(out_pc), .out_inst(out_inst), .out_pred(out_pred)
    );

endmodule

`default_nettype wire

// File: source/inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_cfg.svh"

module inst_buffer
    import bpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  branch_flush,
    input  wire logic  push_1,
    input  wire logic  push_2,
    input  wire logic  push_pred_1,
    input  wire logic  push_pred_2,
    input  wire addr_t fetch_pc,
    input  wire inst_t inst_1,
    input  wire inst_t inst_2,
    input  wire logic  out_ready,
    output logic       stall,
    output logic       out_valid,
    output addr_t      out_pc,
    output inst_t      out_inst,
    output logic       out_pred
);

    localparam int unsigned DEPTH = `BUF_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    addr_t pc_mem   [DEPTH];
    inst_t inst_mem [DEPTH];
    logic  pred_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr, wr_ptr_2;
    logic [CNT_W-1:0] count;
    logic [1:0]       n_push;
    logic             pop;

    assign wr_ptr_2 = wr_ptr + PTR_W'(1);
    assign n_push   = {1'b0, push_1} + {1'b0, push_2};
    assign pop      = out_valid && out_ready;

    // Fewer than two free entries
    assign stall     = count > CNT_W'(DEPTH - 2);
    assign out_valid = count != '0;
    assign out_pc    = pc_mem[rd_ptr];
    assign out_inst  = inst_mem[rd_ptr];
    assign out_pred  = pred_mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Storage, slot 2 sits behind slot 1
    always_ff @(posedge clk) begin
        if (push_1) begin
            pc_mem[wr_ptr]   <= fetch_pc;
            inst_mem[wr_ptr] <= inst_1;
            pred_mem[wr_ptr] <= push_pred_1;
        end
        if (push_2) begin
            pc_mem[wr_ptr_2]   <= fetch_pc + 32'd4;
            inst_mem[wr_ptr_2] <= inst_2;
            pred_mem[wr_ptr_2] <= push_pred_2;
        end
    end

    // Flush drops everything, including a pop in the same cycle
    always_ff @(posedge clk) begin
        if (rst || branch_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + CNT_W'(n_push) - CNT_W'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH))
        else $error("inst_buffer: count %0d above depth", count);

endmodule

`default_nettype wire

// File: source/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_cfg.svh"

module pc_gen
    import bpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  stall,
    input  wire logic  branch_flush,
    input  wire logic  redirect,
    input  wire addr_t flush_pc,
    input  wire addr_t redirect_pc,
    output addr_t      fetch_pc
);

    ////////////////////////////////////////////////////////////
    // Fetch address register
    // Flush beats stall, stall beats prediction
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= `RESET_PC;
        end else if (branch_flush) begin
            fetch_pc <= flush_pc;
        end else if (stall) begin
            fetch_pc <= fetch_pc;
        end else if (redirect) begin
            fetch_pc <= redirect_pc;
        end else begin
            // Two words per fetch
            fetch_pc <= fetch_pc + 32'd8;
        end
    end

    // Catches a misaligned flush or BTB target
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        fetch_pc[1:0] == 2'b00)
        else $error("pc_gen: fetch_pc %h not word aligned", fetch_pc);

endmodule

`default_nettype wire

// File: testbench/tb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_cfg.svh"

module tb_frontend
    import bpu_pkg::*;
();

    localparam int CYCLE_LIMIT = 6 * 400;

    // Branch sites where BR2 sits in slot 2 and NB is a non-branch with a BTB entry
    localparam addr_t BR1 = 32'h1c00_0120;
    localparam addr_t BR2 = 32'h1c00_0244;
    localparam addr_t BR3 = 32'h1c00_0368;
    localparam addr_t NB  = 32'h1c00_0370;
    localparam addr_t BR4 = 32'h1c00_0378;

    logic  clk, rst, update_en, update_taken, branch_flush, out_ready, out_valid, out_pred;
    addr_t fetch_pc, update_pc, update_target, flush_pc, out_pc;
    inst_t inst_1, inst_2, out_inst;
    int    seed, checks, errors, test_err;
    int    cycles = 0;
    logic [31:0] mix;

    // Reference copy of the predictor tables
    bht_cnt_t m_cnt    [2 ** `BHT_IDX_W];
    logic     m_valid  [2 ** `BTB_IDX_W];
    btb_tag_t m_tag    [2 ** `BTB_IDX_W];
    addr_t    m_target [2 ** `BTB_IDX_W];

    addr_t exp_pc [$];
    inst_t exp_inst [$];
    logic  exp_pred [$];

    frontend_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Instruction memory and predictor model

    function automatic inst_t mem_word(input addr_t a, input logic [31:0] m);
        inst_t w;
        w = (a * 32'h9e37_79b1) ^ {a[12:0], a[31:13]} ^ m;
        if (a == BR1 || a == BR2 || a == BR3 || a == BR4) begin
            w[31:26] = 6'h15;
        end else if (a == NB) begin
            w[31:26] = 6'h03;
        end
        return w;
    endfunction

    assign inst_1 = mem_word(fetch_pc, mix);
    assign inst_2 = mem_word(fetch_pc + 32'd4, mix);

    function automatic logic model_pred(input addr_t pc, input inst_t w);
        logic [`BTB_IDX_W-1:0] ti;
        ti = pc[`BTB_IDX_W+1:2];
        return w[31:26] >= 6'h12 && w[31:26] <= 6'h1b && m_cnt[pc[`BHT_IDX_W+1:2]] >= 2'd2
            && m_valid[ti] && m_tag[ti] == pc[31:`BTB_IDX_W+2];
    endfunction

    task automatic model_update(input addr_t pc, input logic taken, input addr_t target);
        logic [`BHT_IDX_W-1:0] bi;
        bi = pc[`BHT_IDX_W+1:2];
        if (taken && m_cnt[bi] != 2'd3) begin
            m_cnt[bi] = m_cnt[bi] + 2'd1;
        end else if (!taken && m_cnt[bi] != 2'd0) begin
            m_cnt[bi] = m_cnt[bi] - 2'd1;
        end
        if (taken) begin
            m_valid[pc[`BTB_IDX_W+1:2]]  = 1'b1;
            m_tag[pc[`BTB_IDX_W+1:2]]    = pc[31:`BTB_IDX_W+2];
            m_target[pc[`BTB_IDX_W+1:2]] = target;
        end
    endtask

    // Walk the prediction rule pair by pair
    task automatic build_expected(input addr_t start, input int n);
        addr_t pc;
        logic  p1, p2;
        exp_pc.delete();
        exp_inst.delete();
        exp_pred.delete();
        pc = start;
        while (exp_pc.size() < n) begin
            p1 = model_pred(pc, mem_word(pc, mix));
            p2 = model_pred(pc + 32'd4, mem_word(pc + 32'd4, mix));
            exp_pc.push_back(pc);
            exp_inst.push_back(mem_word(pc, mix));
            exp_pred.push_back(p1);
            if (p1) begin
                pc = m_target[pc[`BTB_IDX_W+1:2]];
            end else begin
                exp_pc.push_back(pc + 32'd4);
                exp_inst.push_back(mem_word(pc + 32'd4, mix));
                exp_pred.push_back(p2);
                pc = p2 ? m_target[pc[`BTB_IDX_W+1:2] + 1'b1] : pc + 32'd8;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and checking

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Pops n entries and bursty mode gives long low stretches of out_ready
    task automatic run_stream(input int n, input logic bursty);
        int idx;
        int hold;
        logic [31:0] r;
        idx = 0;
        hold = 0;
        while (idx < n) begin
            @(posedge clk);
            r = $random(seed);
            if (!bursty) begin
                out_ready <= r[0];
            end else if (hold > 0) begin
                hold--;
            end else begin
                out_ready <= !out_ready;
                hold = out_ready ? 2 + int'(r[3:0]) : int'(r[1:0]);
            end
            @(negedge clk);
            if (out_valid && out_ready && !branch_flush) begin
                check("out_pc", out_pc, exp_pc[idx]);
                check("out_inst", out_inst, exp_inst[idx]);
                check("out_pred", 32'(out_pred), 32'(exp_pred[idx]));
                idx++;
            end
        end
    endtask

    // Updates go out while the flush holds the fetch stream
    task automatic train(input addr_t pc, input logic taken, input addr_t target);
        @(posedge clk);
        branch_flush  <= 1'b1;
        update_en     <= 1'b1;
        update_pc     <= pc;
        update_taken  <= taken;
        update_target <= target;
        model_update(pc, taken, target);
    endtask

    task automatic flush_to(input addr_t pc);
        @(posedge clk);
        branch_flush <= 1'b1;
        flush_pc     <= pc;
        update_en    <= 1'b0;
        @(posedge clk);
        branch_flush <= 1'b0;
        // Fetch restarts at the flush address with the buffer empty
        @(negedge clk);
        check("fetch_pc", fetch_pc, pc);
        check("out_valid", 32'(out_valid), 32'h0);
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_err) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_err);
        end
        test_err = errors;
    endtask

    initial begin
        seed = 32'hb4ea_1139;
        mix = $random(seed);
        rst = 1'b1;
        update_en = 1'b0;
        update_taken = 1'b0;
        update_pc = '0;
        update_target = '0;
        branch_flush = 1'b0;
        flush_pc = `RESET_PC;
        out_ready = 1'b0;
        checks = 0;
        errors = 0;
        test_err = 0;
        foreach (m_cnt[i]) m_cnt[i] = 2'd1;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check("out_valid", 32'(out_valid), 32'h0);
        check("fetch_pc", fetch_pc, `RESET_PC);
        build_expected(`RESET_PC, 16);
        run_stream(16, 1'b0);
        end_test(1, "sequential stream after reset");

        repeat (2) train(BR1, 1'b1, 32'h1c00_0400);
        flush_to(BR1 - 32'd8);
        build_expected(BR1 - 32'd8, 10);
        run_stream(10, 1'b0);
        end_test(2, "taken branch in slot 1");

        repeat (2) train(BR2, 1'b1, 32'h1c00_0600);
        flush_to(BR2 - 32'd12);
        build_expected(BR2 - 32'd12, 10);
        run_stream(10, 1'b0);
        end_test(3, "taken branch in slot 2");

        repeat (3) train(BR3, 1'b1, 32'h1c00_0700);
        repeat (3) train(BR3, 1'b0, 32'h1c00_0700);
        train(NB, 1'b1, 32'h1c00_0800);
        repeat (3) train(BR4, 1'b1, 32'h1c00_0900);
        train(BR4, 1'b0, 32'h1c00_0900);
        flush_to(32'h1c00_0360);
        build_expected(32'h1c00_0360, 12);
        run_stream(12, 1'b0);
        end_test(4, "not-taken counter, non-branch hit, saturation");

        flush_to(32'h1c00_0100);
        build_expected(32'h1c00_0100, 40);
        run_stream(40, 1'b1);
        end_test(5, "back-pressure with long ready gaps");

        flush_to(32'h1c00_0340);
        build_expected(32'h1c00_0340, 6);
        run_stream(6, 1'b0);
        flush_to(32'h1c00_0a00);
        build_expected(32'h1c00_0a00, 8);
        run_stream(8, 1'b0);
        end_test(6, "flush mid-stream");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the stream stopped making progress", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
